//--- dv/booth_mul_tb.sv
module booth_mul_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import booth_pkg::*;

    localparam int NUM_RANDOM = 200;
    localparam int TIMEOUT    = 100;
    localparam int LATENCY    = 8;
    localparam int POKE_INDEX = 1;     // Vector that gets a start while busy

    typedef struct packed {
        logic [1:0]  mode;
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] expected;
    } vector_t;

    logic clk;
    logic rst;
    logic start;
    mul_mode_e mode;
    logic [OP_W-1:0] a;
    logic [OP_W-1:0] b;
    prod_t product;
    logic done;
    logic ready;

    vector_t vectors [$];
    int errors;
    int timeouts;

    booth_mul_top DUT (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .mode    (mode),
        .a       (a),
        .b       (b),
        .product (product),
        .done    (done),
        .ready   (ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Exact product with each operand taken as signed or unsigned
    function automatic logic [63:0] exact_product(logic [1:0] m, logic [31:0] x,
                                                  logic [31:0] y);
        logic [63:0] xw;
        logic [63:0] yw;
        logic x_signed;
        logic y_signed;
        x_signed = (m == MODE_SS) || (m == MODE_SU);
        y_signed = (m == MODE_SS);
        xw = x_signed ? {{32{x[31]}}, x} : {32'h0, x};
        yw = y_signed ? {{32{y[31]}}, y} : {32'h0, y};
        return xw * yw;
    endfunction

    task automatic add_vector(input logic [1:0] m, input logic [31:0] x,
                              input logic [31:0] y, input logic [63:0] expected);
        vector_t v;
        v.mode = m;
        v.a = x;
        v.b = y;
        v.expected = expected;
        vectors.push_back(v);
    endtask

    task automatic build_table();
        logic [1:0] m;
        logic [31:0] x;
        logic [31:0] y;
        add_vector(2'd0, 32'h00000000, 32'h12345678, 64'h0000000000000000);
        add_vector(2'd0, 32'hffffffff, 32'hffffffff, 64'h0000000000000001);
        add_vector(2'd0, 32'h80000000, 32'h80000000, 64'h4000000000000000);
        add_vector(2'd0, 32'h00000003, 32'hfffffffb, 64'hfffffffffffffff1);
        add_vector(2'd0, 32'h7fffffff, 32'h80000000, 64'hc000000080000000);
        add_vector(2'd0, 32'h7fffffff, 32'h7fffffff, 64'h3fffffff00000001);
        add_vector(2'd1, 32'hffffffff, 32'hffffffff, 64'hfffffffe00000001);
        add_vector(2'd1, 32'hffffffff, 32'h80000000, 64'h7fffffff80000000);
        add_vector(2'd1, 32'h00010000, 32'h00010000, 64'h0000000100000000);
        add_vector(2'd2, 32'hffffffff, 32'hffffffff, 64'hffffffff00000001);
        add_vector(2'd2, 32'hffffffff, 32'h80000000, 64'hffffffff80000000);
        add_vector(2'd2, 32'h80000000, 32'hffffffff, 64'h8000000080000000);
        add_vector(2'd2, 32'h00000007, 32'hffffffff, 64'h00000006fffffff9);
        add_vector(2'd3, 32'hffffffff, 32'hffffffff, 64'hfffffffe00000001);  // Reserved mode
        add_vector(2'd3, 32'hffffffff, 32'h00000002, 64'h00000001fffffffe);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            m = 2'($urandom % 3);
            x = $urandom;
            y = $urandom;
            add_vector(m, x, y, exact_product(m, x, y));
        end
    endtask

    task automatic wait_for_ready();
        int cycles;
        cycles = 0;
        while (!ready && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!ready) begin
            $display("ready stayed low for %0d cycles", TIMEOUT);
            timeouts++;
        end
    endtask

    task automatic apply_vector(input vector_t v, input bit poke_busy);
        int cycles;
        bit seen;
        prod_t held;
        wait_for_ready();
        start = 1'b1;
        mode = mul_mode_e'(v.mode);
        a = v.a;
        b = v.b;
        @(negedge clk);     // Accepted at the edge in between
        start = 1'b0;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles <= TIMEOUT) begin
            if (done) begin
                seen = 1'b1;
            end else begin
                if (ready) begin
                    $display("mismatch ready: got 0x1 expected 0x0 (cycle %0d)", cycles);
                    errors++;
                end
                if (poke_busy && cycles == 3) begin
                    // Different operands, must not disturb the running multiply
                    start = 1'b1;
                    mode = MODE_UU;
                    a = v.a ^ 32'h5a5a5a5a;
                    b = ~v.b;
                end else begin
                    start = 1'b0;
                end
                @(negedge clk);
                cycles++;
            end
        end
        start = 1'b0;
        if (!seen) begin
            $display("done never rose within %0d cycles of start", TIMEOUT);
            timeouts++;
            return;
        end
        if (cycles != LATENCY) begin
            $display("mismatch latency: got 0x%h expected 0x%h", cycles, LATENCY);
            errors++;
        end
        if (!ready) begin
            $display("mismatch ready: got 0x0 expected 0x1 (with done)");
            errors++;
        end
        if (product !== v.expected) begin
            $display("mismatch product: got 0x%h expected 0x%h (mode %0d a 0x%h b 0x%h)",
                     product, v.expected, v.mode, v.a, v.b);
            errors++;
        end
        held = product;
        @(negedge clk);
        if (done !== 1'b0) begin
            $display("mismatch done: got 0x%h expected 0x0 (cycle after done)", done);
            errors++;
        end
        if (poke_busy) begin
            // Ignored start leaves no trace
            for (int i = 0; i < 20; i++) begin
                if (done !== 1'b0) begin
                    $display("mismatch done: got 0x%h expected 0x0 (after ignored start)",
                             done);
                    errors++;
                end
                if (product !== held) begin
                    $display("mismatch product: got 0x%h expected 0x%h (held)", product, held);
                    errors++;
                end
                @(negedge clk);
            end
        end
    endtask

    initial begin
        errors = 0;
        timeouts = 0;
        void'($urandom(32'hedf97717));
        rst = 1'b1;
        start = 1'b0;
        mode = MODE_SS;
        a = '0;
        b = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (done !== 1'b0) begin
            $display("mismatch done: got 0x%h expected 0x0 (after reset)", done);
            errors++;
        end
        if (ready !== 1'b1) begin
            $display("mismatch ready: got 0x%h expected 0x1 (after reset)", ready);
            errors++;
        end
        build_table();
        for (int i = 0; i < vectors.size(); i++) begin
            apply_vector(vectors[i], i == POKE_INDEX);
        end
        $display("%0d vectors, %0d errors, %0d timeouts", vectors.size(), errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- hw/booth_accumulator.sv
module booth_accumulator (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   bank_full,
    input  booth_pkg::pp_t [booth_pkg::LANES-1:0]  pp_lo,
    input  booth_pkg::pp_t [booth_pkg::LANES-1:0]  pp_hi,
    input  booth_pkg::pp_t                         pp_top,
    output booth_pkg::prod_t                       product,
    output logic                                   done
);
    import booth_pkg::*;

    localparam int NUM_PP = LANES * PASSES;
    localparam int STEPS  = 4;
    localparam int TERMS  = NUM_PP / STEPS;

    // Partial product index summed at each step, pairs from both ends
    localparam int ORDER [STEPS][TERMS] = '{
        '{15, 0, 8, 7},
        '{13, 2, 10, 5},
        '{11, 4, 12, 3},
        '{9, 6, 14, 1}
    };

    pp_t all_pp [NUM_PP];
    logic [$clog2(STEPS)-1:0] step;
    logic busy;
    prod_t step_sum;

    function automatic prod_t shift_ext(pp_t p, int sh);
        prod_t wide;
        wide = {{(PROD_W - PP_W){p[PP_W-1]}}, p};
        return wide << sh;
    endfunction

    always_comb begin
        for (int j = 0; j < LANES; j++) begin
            all_pp[j] = pp_lo[j];
            all_pp[j + LANES] = pp_hi[j];
        end
    end

    always_comb begin
        step_sum = '0;
        for (int i = 0; i < TERMS; i++) begin
            step_sum = step_sum + shift_ext(all_pp[ORDER[step][i]], 2 * ORDER[step][i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            step <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (bank_full) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == $bits(step)'(STEPS - 1)) begin   // Last group
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Top term seeds the sum
    always_ff @(posedge clk) begin
        if (bank_full)
            product <= shift_ext(pp_top, OP_W);
        else if (busy)
            product <= product + step_sum;
    end

endmodule

//--- hw/booth_mul_top.sv
module booth_mul_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  booth_pkg::mul_mode_e       mode,
    input  logic [booth_pkg::OP_W-1:0] a,
    input  logic [booth_pkg::OP_W-1:0] b,
    output booth_pkg::prod_t           product,
    output logic                       done,
    output logic                       ready
);
    import booth_pkg::*;

    ext_t multiplicand;
    digit_vec_t digits;
    logic [1:0] top_digit;
    logic pass;
    logic digits_valid;
    pp_t [LANES-1:0] pp_lo;
    pp_t [LANES-1:0] pp_hi;
    pp_t pp_top;
    logic bank_full;

    booth_operand_seq u_seq (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .mode         (mode),
        .a            (a),
        .b            (b),
        .acc_done     (done),
        .ready        (ready),
        .multiplicand (multiplicand),
        .digits       (digits),
        .top_digit    (top_digit),
        .pass         (pass),
        .digits_valid (digits_valid)
    );

    booth_pp_bank u_bank (
        .clk          (clk),
        .rst          (rst),
        .multiplicand (multiplicand),
        .digits       (digits),
        .top_digit    (top_digit),
        .pass         (pass),
        .digits_valid (digits_valid),
        .pp_lo        (pp_lo),
        .pp_hi        (pp_hi),
        .pp_top       (pp_top),
        .bank_full    (bank_full)
    );

    booth_accumulator u_acc (
        .clk       (clk),
        .rst       (rst),
        .bank_full (bank_full),
        .pp_lo     (pp_lo),
        .pp_hi     (pp_hi),
        .pp_top    (pp_top),
        .product   (product),
        .done      (done)
    );

endmodule

//--- hw/booth_operand_seq.sv
module booth_operand_seq (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  booth_pkg::mul_mode_e       mode,
    input  logic [booth_pkg::OP_W-1:0] a,
    input  logic [booth_pkg::OP_W-1:0] b,
    input  logic                       acc_done,
    output logic                       ready,
    output booth_pkg::ext_t            multiplicand,
    output booth_pkg::digit_vec_t      digits,
    output logic [1:0]                 top_digit,
    output logic                       pass,
    output logic                       digits_valid
);
    import booth_pkg::*;

    localparam int PASS_BITS = OP_W / PASSES;

    seq_state_e state;
    ext_t a_ext;
    ext_t b_ext;
    ext_t b_reg;
    logic [EXT_W:0] b_pad;      // b with the implicit zero at bit -1
    digit_vec_t digit_nxt;
    logic accept;

    // Free again in the same cycle the accumulator reports done
    assign ready = (state == IDLE) || acc_done;
    assign accept = start && ready;

    always_comb begin
        case (mode)
            MODE_SS: begin
                a_ext = {a[OP_W-1], a};
                b_ext = {b[OP_W-1], b};
            end
            MODE_SU: begin
                a_ext = {a[OP_W-1], a};
                b_ext = {1'b0, b};
            end
            default: begin
                a_ext = {1'b0, a};
                b_ext = {1'b0, b};
            end
        endcase
    end

    assign b_pad = {b_reg, 1'b0};

    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            digit_nxt[k] = b_pad[(state == PASS1 ? PASS_BITS : 0) + 2 * k +: 3];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            digits_valid <= 1'b0;
        end else begin
            digits_valid <= 1'b0;
            case (state)
                PASS0: begin
                    digits_valid <= 1'b1;
                    state <= PASS1;
                end
                PASS1: begin
                    digits_valid <= 1'b1;
                    state <= WAIT_DONE;
                end
                default: begin
                    if (accept)
                        state <= PASS0;
                    else if (acc_done)
                        state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            multiplicand <= a_ext;
            b_reg <= b_ext;
        end
        digits <= digit_nxt;
        pass <= (state == PASS1);
        top_digit <= b_reg[EXT_W-1 -: 2];
    end

endmodule

//--- hw/booth_pkg.sv
package booth_pkg;

    localparam int OP_W   = 32;
    localparam int EXT_W  = OP_W + 1;   // One sign or zero bit on top
    localparam int PP_W   = EXT_W + 1;
    localparam int PROD_W = 2 * OP_W;
    localparam int LANES  = 8;
    localparam int PASSES = 2;

    // Encoding 3 is reserved and treated as unsigned
    typedef enum logic [1:0] {
        MODE_SS = 2'd0,
        MODE_UU = 2'd1,
        MODE_SU = 2'd2
    } mul_mode_e;

    typedef enum logic [1:0] {
        IDLE,
        PASS0,
        PASS1,
        WAIT_DONE
    } seq_state_e;

    typedef logic signed [EXT_W-1:0] ext_t;
    typedef logic [2:0] digit_t;
    typedef digit_t [LANES-1:0] digit_vec_t;
    typedef logic signed [PP_W-1:0] pp_t;
    typedef logic [PROD_W-1:0] prod_t;

    // Radix-4 recoding of one overlapping three-bit group
    function automatic pp_t booth_pp(digit_t grp, ext_t m);
        pp_t m1;
        pp_t m2;
        m1 = {m[EXT_W-1], m};
        m2 = {m, 1'b0};
        case (grp)
            3'b001, 3'b010: return m1;
            3'b011:         return m2;
            3'b100:         return -m2;
            3'b101, 3'b110: return -m1;
            default:        return '0;
        endcase
    endfunction

    // Weight 2^32 digit, from bits 32 and 31 of the extended b
    function automatic pp_t booth_pp_top(logic [1:0] grp, ext_t m);
        pp_t m1;
        m1 = {m[EXT_W-1], m};
        case (grp)
            2'b01:   return m1;
            2'b10:   return -m1;
            default: return '0;
        endcase
    endfunction

endpackage

//--- hw/booth_pp_bank.sv
module booth_pp_bank (
    input  logic                                   clk,
    input  logic                                   rst,
    input  booth_pkg::ext_t                        multiplicand,
    input  booth_pkg::digit_vec_t                  digits,
    input  logic [1:0]                             top_digit,
    input  logic                                   pass,
    input  logic                                   digits_valid,
    output booth_pkg::pp_t [booth_pkg::LANES-1:0]  pp_lo,
    output booth_pkg::pp_t [booth_pkg::LANES-1:0]  pp_hi,
    output booth_pkg::pp_t                         pp_top,
    output logic                                   bank_full
);
    import booth_pkg::*;

    pp_t [LANES-1:0] recoded;

    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            recoded[k] = booth_pp(digits[k], multiplicand);
        end
    end

    // High half is always the second pass
    always_ff @(posedge clk) begin
        if (rst)
            bank_full <= 1'b0;
        else
            bank_full <= digits_valid && pass;
    end

    always_ff @(posedge clk) begin
        if (digits_valid) begin
            if (pass) begin
                pp_hi <= recoded;
            end else begin
                pp_lo <= recoded;
                pp_top <= booth_pp_top(top_digit, multiplicand);
            end
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module booth_mul_tb \
    -Mdir obj_dir -o booth_mul_sim

./obj_dir/booth_mul_sim | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- src.f
hw/booth_pkg.sv
hw/booth_operand_seq.sv
hw/booth_pp_bank.sv
hw/booth_accumulator.sv
hw/booth_mul_top.sv
dv/booth_mul_tb.sv
